// File: include/hc_defs.svh
// Host channel shared definitions
`ifndef HC_DEFS_SVH
`define HC_DEFS_SVH

// Wishbone data word and word address widths
`define HC_DATA_WIDTH 32
`define HC_ADDR_WIDTH 16

// CSR index codes as seen on the host configuration port
`define HC_CSR_FROM_HOST_BASE 3'd0
`define HC_CSR_TO_HOST_BASE   3'd1
`define HC_CSR_STATUS_ADDR    3'd2
`define HC_CSR_FROM_HOST_PROD 3'd3
`define HC_CSR_CONTROL        3'd4

`endif

// File: source/hc_pkg.sv
// Host channel package
`include "hc_defs.svh"

package hc_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    localparam int data_width  = `HC_DATA_WIDTH;
    localparam int addr_width  = `HC_ADDR_WIDTH;
    localparam int index_width = 8;
    localparam int fifo_depth  = 8;

    // CSR index codes stay in step with the testbench through the header
    localparam logic [2:0] csr_from_host_base = `HC_CSR_FROM_HOST_BASE;
    localparam logic [2:0] csr_to_host_base   = `HC_CSR_TO_HOST_BASE;
    localparam logic [2:0] csr_status_addr    = `HC_CSR_STATUS_ADDR;
    localparam logic [2:0] csr_from_host_prod = `HC_CSR_FROM_HOST_PROD;
    localparam logic [2:0] csr_control        = `HC_CSR_CONTROL;

    // ==================================================
    // CSR data word
    // ==================================================

    // Control view with the from-host enable in bit 0
    typedef struct packed
    {
        logic [data_width-7:0] unused;
        logic [3:0]            ring_log2;
        logic                  to_host_enable;
        logic                  from_host_enable;
    } hc_csr_control;

    // The same word is either an address or index, or the control fields
    typedef union packed
    {
        logic [data_width-1:0] raw;
        hc_csr_control         control;
    } hc_csr_word;

endpackage

// File: source/hc_csr.sv
// Host channel CSR block
`timescale 1ns/1ps

module hc_csr
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           csr_write,
    input  logic [2:0]                     csr_index,
    input  hc_pkg::hc_csr_word             csr_data,
    output logic [hc_pkg::addr_width-1:0]  from_host_base,
    output logic [hc_pkg::addr_width-1:0]  to_host_base,
    output logic [hc_pkg::addr_width-1:0]  status_addr,
    output logic [hc_pkg::index_width-1:0] from_host_prod,
    output logic [hc_pkg::index_width-1:0] ring_mask,
    output logic                           from_host_enable,
    output logic                           to_host_enable
);

    // Each write lands in one register and is visible the next cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            from_host_base   <= '0;
            to_host_base     <= '0;
            status_addr      <= '0;
            from_host_prod   <= '0;
            // Full index range until software picks a ring size
            ring_mask        <= '1;
            from_host_enable <= 1'b0;
            to_host_enable   <= 1'b0;
        end
        else if (csr_write)
        begin
            case (csr_index)
                hc_pkg::csr_from_host_base:
                    from_host_base <= csr_data.raw[hc_pkg::addr_width-1:0];
                hc_pkg::csr_to_host_base:
                    to_host_base <= csr_data.raw[hc_pkg::addr_width-1:0];
                hc_pkg::csr_status_addr:
                    status_addr <= csr_data.raw[hc_pkg::addr_width-1:0];
                hc_pkg::csr_from_host_prod:
                    from_host_prod <= csr_data.raw[hc_pkg::index_width-1:0];
                hc_pkg::csr_control:
                begin
                    from_host_enable <= csr_data.control.from_host_enable;
                    to_host_enable   <= csr_data.control.to_host_enable;
                    // The mask is the size minus one and a shift past the width leaves all ones
                    ring_mask <= ~({hc_pkg::index_width{1'b1}} << csr_data.control.ring_log2);
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// File: source/hc_bus_arbiter.sv
// Wishbone round-robin arbiter
`timescale 1ns/1ps

module hc_bus_arbiter
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          req_cyc_0,
    input  logic                          req_stb_0,
    input  logic                          req_we_0,
    input  logic [hc_pkg::addr_width-1:0] req_adr_0,
    input  logic [hc_pkg::data_width-1:0] req_dat_w_0,
    output logic                          req_ack_0,
    input  logic                          req_cyc_1,
    input  logic                          req_stb_1,
    input  logic                          req_we_1,
    input  logic [hc_pkg::addr_width-1:0] req_adr_1,
    input  logic [hc_pkg::data_width-1:0] req_dat_w_1,
    output logic                          req_ack_1,
    input  logic                          req_cyc_2,
    input  logic                          req_stb_2,
    input  logic                          req_we_2,
    input  logic [hc_pkg::addr_width-1:0] req_adr_2,
    input  logic [hc_pkg::data_width-1:0] req_dat_w_2,
    output logic                          req_ack_2,
    output logic [hc_pkg::data_width-1:0] req_dat_r,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [hc_pkg::addr_width-1:0] wb_adr,
    output logic [hc_pkg::data_width-1:0] wb_dat_w,
    input  logic [hc_pkg::data_width-1:0] wb_dat_r,
    input  logic                          wb_ack
);

    // One-hot grant that is zero while the bus is idle
    logic [2:0] grant;
    logic [1:0] last;
    logic [2:0] req_vec;
    logic [2:0] next_grant;
    logic [1:0] next_last;

    assign req_vec = {req_cyc_2, req_cyc_1, req_cyc_0};

    // ==================================================
    // Round-robin pick
    // ==================================================

    always_comb
    begin
        int cand;
        next_grant = '0;
        next_last  = last;
        // Scan from the farthest engine inward so the one right after last wins
        for (int step = 3; step >= 1; step--)
        begin
            cand = (int'(last) + step) % 3;
            if (req_vec[cand])
            begin
                next_grant = 3'b001 << cand;
                next_last  = 2'(cand);
            end
        end
    end

    // Grant is taken only from idle and held until the owner's ack
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            grant <= '0;
            // Engine 0 comes first after reset
            last  <= 2'd2;
        end
        else if (grant == '0)
        begin
            grant <= next_grant;
            last  <= next_last;
        end
        else if (wb_ack)
        begin
            grant <= '0;
        end
    end

    // ==================================================
    // Bus multiplexer
    // ==================================================

    assign wb_cyc = |(grant & req_vec);
    assign wb_stb = |(grant & {req_stb_2, req_stb_1, req_stb_0});
    assign wb_we  = |(grant & {req_we_2, req_we_1, req_we_0});

    always_comb
    begin
        wb_adr   = '0;
        wb_dat_w = '0;
        if (grant[0])
        begin
            wb_adr   = req_adr_0;
            wb_dat_w = req_dat_w_0;
        end
        if (grant[1])
        begin
            wb_adr   = req_adr_1;
            wb_dat_w = req_dat_w_1;
        end
        if (grant[2])
        begin
            wb_adr   = req_adr_2;
            wb_dat_w = req_dat_w_2;
        end
    end

    // Only the owner of the cycle sees the ack
    assign req_ack_0 = grant[0] && wb_ack;
    assign req_ack_1 = grant[1] && wb_ack;
    assign req_ack_2 = grant[2] && wb_ack;
    assign req_dat_r = wb_dat_r;

endmodule

// File: source/hc_fifo_from_host.sv
// From-host ring reader
`timescale 1ns/1ps

module hc_fifo_from_host
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [hc_pkg::addr_width-1:0]  from_host_base,
    input  logic [hc_pkg::index_width-1:0] from_host_prod,
    input  logic [hc_pkg::index_width-1:0] ring_mask,
    input  logic                           from_host_enable,
    output logic                           req_cyc,
    output logic                           req_stb,
    output logic                           req_we,
    output logic [hc_pkg::addr_width-1:0]  req_adr,
    output logic [hc_pkg::data_width-1:0]  req_dat_w,
    input  logic                           req_ack,
    input  logic [hc_pkg::data_width-1:0]  req_dat_r,
    output logic [hc_pkg::index_width-1:0] from_host_cons,
    output logic [hc_pkg::data_width-1:0]  rx_data,
    output logic                           rx_rdy,
    input  logic                           rx_enable
);

    logic [hc_pkg::data_width-1:0]           fifo_mem [hc_pkg::fifo_depth];
    logic [$clog2(hc_pkg::fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(hc_pkg::fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(hc_pkg::fifo_depth):0]     count;
    logic                                    push;
    logic                                    pop;
    logic                                    has_room;
    logic                                    start_read;

    // Read-only master
    assign req_stb   = req_cyc;
    assign req_we    = 1'b0;
    assign req_dat_w = '0;

    // Read data is pushed in the ack cycle
    assign push = req_cyc && req_ack;

    // First-word fall-through view of the head
    assign rx_rdy  = (count != '0);
    assign rx_data = fifo_mem[rd_ptr];
    assign pop     = rx_enable && rx_rdy;

    // Only one read is in flight and it starts with a free slot reserved for its word
    assign has_room = (int'(count) < hc_pkg::fifo_depth);

    assign start_read = !req_cyc && from_host_enable &&
                        (from_host_cons != from_host_prod) && has_room;

    // ==================================================
    // Control state
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_cyc        <= 1'b0;
            from_host_cons <= '0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
        end
        else
        begin
            if (start_read)
            begin
                req_cyc <= 1'b1;
            end
            else if (push)
            begin
                // Cycle ends at the ack and the index wraps at the ring size
                req_cyc        <= 1'b0;
                from_host_cons <= (from_host_cons + 1'b1) & ring_mask;
            end

            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Payload registers stay steady for the whole bus cycle
    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= req_dat_r;
        if (start_read)
        begin
            req_adr <= from_host_base +
                {{(hc_pkg::addr_width - hc_pkg::index_width){1'b0}}, from_host_cons};
        end
    end

endmodule

// File: source/hc_fifo_to_host.sv
// To-host ring writer
`timescale 1ns/1ps

module hc_fifo_to_host
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [hc_pkg::addr_width-1:0]  to_host_base,
    input  logic [hc_pkg::index_width-1:0] ring_mask,
    input  logic                           to_host_enable,
    output logic                           req_cyc,
    output logic                           req_stb,
    output logic                           req_we,
    output logic [hc_pkg::addr_width-1:0]  req_adr,
    output logic [hc_pkg::data_width-1:0]  req_dat_w,
    input  logic                           req_ack,
    output logic [hc_pkg::index_width-1:0] to_host_prod,
    input  logic [hc_pkg::data_width-1:0]  tx_data,
    input  logic                           tx_enable,
    output logic                           tx_rdy
);

    logic [hc_pkg::data_width-1:0]           fifo_mem [hc_pkg::fifo_depth];
    logic [$clog2(hc_pkg::fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(hc_pkg::fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(hc_pkg::fifo_depth):0]     count;
    logic                                    push;
    logic                                    pop;
    logic                                    start_write;

    // Write-only master
    assign req_stb = req_cyc;
    assign req_we  = 1'b1;

    // Client side accepts until the FIFO is full
    assign tx_rdy = (int'(count) != hc_pkg::fifo_depth);
    assign push   = tx_enable && tx_rdy;

    // Head leaves the FIFO only once the host has taken it
    assign pop = req_cyc && req_ack;

    assign start_write = !req_cyc && to_host_enable && (count != '0);

    // ==================================================
    // Control state
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_cyc      <= 1'b0;
            to_host_prod <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
        end
        else
        begin
            if (start_write)
            begin
                req_cyc <= 1'b1;
            end
            else if (pop)
            begin
                req_cyc      <= 1'b0;
                to_host_prod <= (to_host_prod + 1'b1) & ring_mask;
            end

            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Head word and its ring slot are captured when the cycle starts
    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= tx_data;
        if (start_write)
        begin
            req_dat_w <= fifo_mem[rd_ptr];
            req_adr   <= to_host_base +
                {{(hc_pkg::addr_width - hc_pkg::index_width){1'b0}}, to_host_prod};
        end
    end

endmodule

// File: source/hc_status_manager.sv
// Host status word writer
`timescale 1ns/1ps

module hc_status_manager
(
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic [hc_pkg::addr_width-1:0]  status_addr,
    input  logic [hc_pkg::index_width-1:0] from_host_cons,
    input  logic [hc_pkg::index_width-1:0] to_host_prod,
    output logic                           req_cyc,
    output logic                           req_stb,
    output logic                           req_we,
    output logic [hc_pkg::addr_width-1:0]  req_adr,
    output logic [hc_pkg::data_width-1:0]  req_dat_w,
    input  logic                           req_ack
);

    // Index values carried by the most recent status write
    logic [hc_pkg::index_width-1:0] last_cons;
    logic [hc_pkg::index_width-1:0] last_prod;
    logic                           changed;
    logic                           start_write;

    assign req_stb = req_cyc;
    assign req_we  = 1'b1;

    assign changed     = (from_host_cons != last_cons) || (to_host_prod != last_prod);
    assign start_write = !req_cyc && changed;

    // Indices that move during a cycle differ again afterwards and trigger one more write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            req_cyc   <= 1'b0;
            last_cons <= '0;
            last_prod <= '0;
        end
        else if (start_write)
        begin
            req_cyc   <= 1'b1;
            last_cons <= from_host_cons;
            last_prod <= to_host_prod;
        end
        else if (req_ack)
        begin
            req_cyc <= 1'b0;
        end
    end

    // To-host producer in the upper half, from-host consumer in the lower half
    always_ff @(posedge clk)
    begin
        if (start_write)
        begin
            req_adr   <= status_addr;
            req_dat_w <= {{(hc_pkg::data_width / 2 - hc_pkg::index_width){1'b0}}, to_host_prod,
                          {(hc_pkg::data_width / 2 - hc_pkg::index_width){1'b0}}, from_host_cons};
        end
    end

endmodule

// File: source/hc_root.sv
// Host channel top level
`timescale 1ns/1ps

module hc_root
(
    input  logic                          clk,
    input  logic                          reset_n,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [hc_pkg::addr_width-1:0] wb_adr,
    output logic [hc_pkg::data_width-1:0] wb_dat_w,
    input  logic [hc_pkg::data_width-1:0] wb_dat_r,
    input  logic                          wb_ack,
    input  logic                          csr_write,
    input  logic [2:0]                    csr_index,
    input  hc_pkg::hc_csr_word            csr_data,
    output logic [hc_pkg::data_width-1:0] rx_data,
    output logic                          rx_rdy,
    input  logic                          rx_enable,
    input  logic [hc_pkg::data_width-1:0] tx_data,
    output logic                          tx_rdy,
    input  logic                          tx_enable
);

    // ==================================================
    // Configuration
    // ==================================================

    logic [hc_pkg::addr_width-1:0]  from_host_base;
    logic [hc_pkg::addr_width-1:0]  to_host_base;
    logic [hc_pkg::addr_width-1:0]  status_addr;
    logic [hc_pkg::index_width-1:0] from_host_prod;
    logic [hc_pkg::index_width-1:0] ring_mask;
    logic                           from_host_enable;
    logic                           to_host_enable;

    hc_csr hc_csr_i
    (
        .clk, .reset_n, .csr_write, .csr_index, .csr_data,
        .from_host_base, .to_host_base, .status_addr, .from_host_prod,
        .ring_mask, .from_host_enable, .to_host_enable
    );

    // ==================================================
    // Engines on arbiter ports 0, 1 and 2 in that order
    // ==================================================

    logic                           fh_cyc, fh_stb, fh_we, fh_ack;
    logic [hc_pkg::addr_width-1:0]  fh_adr;
    logic [hc_pkg::data_width-1:0]  fh_dat_w;
    logic                           th_cyc, th_stb, th_we, th_ack;
    logic [hc_pkg::addr_width-1:0]  th_adr;
    logic [hc_pkg::data_width-1:0]  th_dat_w;
    logic                           st_cyc, st_stb, st_we, st_ack;
    logic [hc_pkg::addr_width-1:0]  st_adr;
    logic [hc_pkg::data_width-1:0]  st_dat_w;
    logic [hc_pkg::data_width-1:0]  bus_dat_r;
    logic [hc_pkg::index_width-1:0] from_host_cons;
    logic [hc_pkg::index_width-1:0] to_host_prod;

    hc_fifo_from_host hc_fifo_from_host_i
    (
        .clk, .reset_n, .from_host_base, .from_host_prod, .ring_mask, .from_host_enable,
        .req_cyc(fh_cyc), .req_stb(fh_stb), .req_we(fh_we), .req_adr(fh_adr),
        .req_dat_w(fh_dat_w), .req_ack(fh_ack), .req_dat_r(bus_dat_r),
        .from_host_cons, .rx_data, .rx_rdy, .rx_enable
    );

    hc_fifo_to_host hc_fifo_to_host_i
    (
        .clk, .reset_n, .to_host_base, .ring_mask, .to_host_enable,
        .req_cyc(th_cyc), .req_stb(th_stb), .req_we(th_we), .req_adr(th_adr),
        .req_dat_w(th_dat_w), .req_ack(th_ack),
        .to_host_prod, .tx_data, .tx_enable, .tx_rdy
    );

    hc_status_manager hc_status_manager_i
    (
        .clk, .reset_n, .status_addr, .from_host_cons, .to_host_prod,
        .req_cyc(st_cyc), .req_stb(st_stb), .req_we(st_we), .req_adr(st_adr),
        .req_dat_w(st_dat_w), .req_ack(st_ack)
    );

    hc_bus_arbiter hc_bus_arbiter_i
    (
        .clk, .reset_n,
        .req_cyc_0(fh_cyc), .req_stb_0(fh_stb), .req_we_0(fh_we), .req_adr_0(fh_adr),
        .req_dat_w_0(fh_dat_w), .req_ack_0(fh_ack),
        .req_cyc_1(th_cyc), .req_stb_1(th_stb), .req_we_1(th_we), .req_adr_1(th_adr),
        .req_dat_w_1(th_dat_w), .req_ack_1(th_ack),
        .req_cyc_2(st_cyc), .req_stb_2(st_stb), .req_we_2(st_we), .req_adr_2(st_adr),
        .req_dat_w_2(st_dat_w), .req_ack_2(st_ack),
        .req_dat_r(bus_dat_r),
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

endmodule

// File: verification/hc_root_properties.sv
// Wishbone handshake properties
`timescale 1ns/1ps

module hc_root_properties
(
    input logic                      clk,
    input logic                      reset_n,
    input logic                      wb_cyc,
    input logic                      wb_stb,
    input logic                      wb_we,
    input logic [`HC_ADDR_WIDTH-1:0] wb_adr,
    input logic [`HC_DATA_WIDTH-1:0] wb_dat_w,
    input logic                      wb_ack,
    input logic [2:0]                grant
);

    // A strobe is only legal inside a bus cycle
    stb_inside_cyc: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb |-> wb_cyc)
        else $error("Wishbone stb is high while cyc is low");

    // The master holds its request until the slave acks it
    request_held: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we)
                                 && $stable(wb_dat_w)))
        else $error("Wishbone request changed before its ack");

    // The arbiter never hands the bus to two engines
    single_grant: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(grant))
        else $error("More than one arbiter grant is set");

endmodule

// Attached to every instance of the top level
bind hc_root hc_root_properties hc_root_properties_i
(
    .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack,
    .grant(hc_bus_arbiter_i.grant)
);

// File: verification/hc_root_tb.sv
// Host channel testbench
`timescale 1ns/1ps
`include "hc_defs.svh"

module hc_root_tb;

    logic                      clk;
    logic                      reset_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`HC_ADDR_WIDTH-1:0] wb_adr;
    logic [`HC_DATA_WIDTH-1:0] wb_dat_w;
    logic [`HC_DATA_WIDTH-1:0] wb_dat_r;
    logic                      wb_ack;
    logic                      csr_write;
    logic [2:0]                csr_index;
    hc_pkg::hc_csr_word        csr_data;
    logic [`HC_DATA_WIDTH-1:0] rx_data;
    logic                      rx_rdy;
    logic                      rx_enable;
    logic [`HC_DATA_WIDTH-1:0] tx_data;
    logic                      tx_rdy;
    logic                      tx_enable;

    // Host memory, client queues and trace bookkeeping
    logic [31:0] mem [256];
    logic [31:0] exp_rx [$];
    logic [31:0] tx_q [$];
    logic [31:0] rnd = 32'hd4a5;
    int          delay;
    bit          waiting;
    int          rx_hold;
    int          rx_count;
    int          line_total;

    hc_root hc_root_i
    (
        .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .csr_write, .csr_index, .csr_data, .rx_data, .rx_rdy, .rx_enable,
        .tx_data, .tx_rdy, .tx_enable
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // ==================================================
    // Host memory slave with a random ack delay
    // ==================================================

    always @(negedge clk)
    begin
        if (wb_ack)
            wb_ack = 1'b0;
        else if (wb_cyc && wb_stb)
        begin
            if (!waiting)
            begin
                waiting = 1'b1;
                rnd = xorshift(rnd);
                delay = int'(rnd[1:0]);
            end
            if (delay == 0)
            begin
                waiting = 1'b0;
                wb_ack = 1'b1;
                if (wb_we)
                    mem[wb_adr[7:0]] = wb_dat_w;
                else
                    wb_dat_r = mem[wb_adr[7:0]];
            end
            else
                delay--;
        end
    end

    // Receive side takes every word unless a hold is running
    always @(negedge clk)
    begin
        if (rx_hold > 0)
        begin
            rx_hold--;
            rx_enable = 1'b0;
        end
        else
            rx_enable = 1'b1;
        // The pop happens at the next rising edge, so the head is stable here
        if (reset_n && rx_enable && rx_rdy)
        begin
            assert (exp_rx.size() > 0)
            else
            begin
                $display("A receive word arrived that the trace does not expect");
                $display("Testbench failed");
                $fatal(1);
            end
            check_value($sformatf("receive word %0d", rx_count), exp_rx.pop_front(), rx_data);
            rx_count++;
        end
    end

    // Transmit side offers queued words while the FIFO has room
    always @(negedge clk)
    begin
        if (reset_n && tx_q.size() > 0 && tx_rdy)
        begin
            tx_data = tx_q.pop_front();
            tx_enable = 1'b1;
        end
        else
            tx_enable = 1'b0;
    end

    // Ends a run that stops making progress
    initial
    begin
        wait (line_total > 0);
        repeat (200 * line_total) @(posedge clk);
        $display("Timeout: the trace did not finish in time");
        $display("Testbench failed");
        $fatal(1);
    end

    // ==================================================
    // Trace replay
    // ==================================================

    task automatic write_csr(input logic [2:0] index, input logic [31:0] value);
        @(negedge clk);
        csr_write = 1'b1;
        csr_index = index;
        csr_data.raw = value;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    // Idle means queues drained and 30 cycles without a bus cycle
    task automatic wait_idle();
        int idle;
        idle = 0;
        while (tx_q.size() > 0 || exp_rx.size() > 0)
            @(negedge clk);
        while (idle < 30)
        begin
            @(negedge clk);
            idle = wb_cyc ? 0 : idle + 1;
        end
    endtask

    initial
    begin
        int                fd;
        int                code;
        int                step;
        int                n;
        logic [8*200-1:0]  text;
        logic [8*8-1:0]    op;
        logic [31:0]       a;
        logic [31:0]       b;
        reset_n = 1'b0;
        wb_dat_r = '0;
        wb_ack = 1'b0;
        csr_write = 1'b0;
        csr_index = '0;
        csr_data.raw = '0;
        rx_enable = 1'b0;
        tx_data = '0;
        tx_enable = 1'b0;
        rx_hold = 0;
        rx_count = 0;
        line_total = 0;
        step = 0;
        // Fill pattern carries the full word address
        for (int i = 0; i < 256; i++)
            mem[i] = {24'hf11e00, 8'(i)};
        fd = $fopen("verification/hc_trace.txt", "r");
        if (fd == 0)
        begin
            $display("The trace file could not be opened");
            $display("Testbench failed");
            $fatal(1);
        end
        n = 0;
        while (!$feof(fd))
        begin
            code = $fgets(text, fd);
            if (code > 0)
                n++;
        end
        $fclose(fd);
        line_total = n;
        fd = $fopen("verification/hc_trace.txt", "r");
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        while ($fscanf(fd, "%s", op) == 1)
        begin
            step++;
            if (op == "#")
                code = $fgets(text, fd);
            else if (op == "C")
            begin
                code = $fscanf(fd, "%h %h", a, b);
                write_csr(a[2:0], b);
            end
            else if (op == "P")
            begin
                code = $fscanf(fd, "%h %h %d", a, b, n);
                for (int k = 0; k < n; k++)
                    mem[a[7:0] + 8'(k)] = b + k;
            end
            else if (op == "R")
            begin
                code = $fscanf(fd, "%h %d", b, n);
                for (int k = 0; k < n; k++)
                    exp_rx.push_back(b + k);
            end
            else if (op == "T")
            begin
                code = $fscanf(fd, "%h %d", b, n);
                for (int k = 0; k < n; k++)
                    tx_q.push_back(b + k);
            end
            else if (op == "M")
            begin
                code = $fscanf(fd, "%h %h", a, b);
                check_value($sformatf("step %0d memory %h", step, a[7:0]), b, mem[a[7:0]]);
            end
            else if (op == "N")
            begin
                code = $fscanf(fd, "%d", n);
                check_value($sformatf("step %0d receive count", step), n, rx_count);
            end
            else if (op == "H")
            begin
                code = $fscanf(fd, "%d", n);
                rx_hold = n;
            end
            else if (op == "W")
                wait_idle();
            else
            begin
                $display("The trace holds an unknown op at step %0d", step);
                $display("Testbench failed");
                $fatal(1);
            end
        end
        $fclose(fd);
        // Every expected word must have been consumed
        if (exp_rx.size() == 0 && tx_q.size() == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("Words were left over at the end of the trace");
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

// File: verification/hc_trace.txt
# op and hex values, counts in decimal: C index data, P addr first n, R first n, T first n
# M addr data checks memory, W waits for idle, H n holds rx off, N n checks receive count
C 0 00000010
C 1 00000040
C 2 00000080
C 4 0000000c
P 10 a0000000 8
C 3 00000005
T 11110000 3
W
N 0
M 40 f11e0040
M 80 f11e0080
C 4 0000000f
R a0000000 5
W
N 5
M 40 11110000
M 42 11110002
M 80 00030005
C 4 00000013
P 18 b0000008 8
H 150
C 3 00000003
R a0000005 3
R b0000008 8
R a0000000 3
T 22220003 10
W
M 43 22220003
M 4c 2222000c
M 80 000d0003
T 33330000 5
W
M 4d 33330000
M 40 33330003
M 41 33330004
M 42 11110002
M 80 00020003
N 19

// File: list.f
+incdir+include
source/hc_pkg.sv
source/hc_csr.sv
source/hc_bus_arbiter.sv
source/hc_fifo_from_host.sv
source/hc_fifo_to_host.sv
source/hc_status_manager.sv
source/hc_root.sv
verification/hc_root_properties.sv
verification/hc_root_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module hc_root_tb \
    && ./obj_dir/Vhc_root_tb | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }
